//--- Makefile
# Verilator build and run for the peripheral subsystem testbench

TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = soc_periph_tb
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the simulator status is ignored, the log search decides pass or fail
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- src/apb_slot_decoder.sv
// apb address decode for the peripheral slots, forms selects and returns read data and response
`default_nettype none

`include "soc_periph_consts.svh"

module apb_slot_decoder (
  input  soc_periph_pkg::apb_addr_t paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  soc_periph_pkg::apb_data_t pll_rdata,
  input  soc_periph_pkg::apb_data_t console_rdata,
  output logic                      pll_sel,
  output logic                      console_sel,
  output soc_periph_pkg::reg_idx_t  reg_idx,
  output soc_periph_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr
);

  import soc_periph_pkg::*;

  slot_t slot;
  logic  access;

  // slot field to slot, anything else is unmapped
  always_comb begin
    case (paddr[`SLOT_FIELD_HI:`SLOT_FIELD_LO])
      `PLL_SLOT:     slot = SLOT_PLL;
      `CONSOLE_SLOT: slot = SLOT_CONSOLE;
      default:       slot = SLOT_NONE;
    endcase
  end

  assign pll_sel     = psel && (slot == SLOT_PLL);
  assign console_sel = psel && (slot == SLOT_CONSOLE);

  assign reg_idx = paddr[3:2];

  // zero wait states, every access completes in its first access cycle
  assign access  = psel && penable;
  assign pready  = access;
  assign pslverr = access && (slot == SLOT_NONE);

  always_comb begin
    case (slot)
      SLOT_PLL:     prdata = pll_rdata;
      SLOT_CONSOLE: prdata = console_rdata;
      default:      prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/clock_reset_gen.sv
// core reset synchronizer and divide-by-8 monitor clock, both running from dev_clk
`default_nettype none

`include "soc_periph_consts.svh"

module clock_reset_gen (
  input  logic dev_clk,
  input  logic rst_n,
  output logic core_rst_n,
  output logic core_clk_mon
);

  localparam logic [1:0] MON_LAST = 2'(`MON_HALF_PERIOD - 1);

  logic [`RST_SYNC_STAGES-1:0] rst_sync;
  logic [1:0]                  mon_cnt;

  // asserts with rst_n, releases after the chain fills with ones
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync <= '0;
    end else begin
      rst_sync <= {rst_sync[`RST_SYNC_STAGES-2:0], 1'b1};
    end
  end

  assign core_rst_n = rst_sync[`RST_SYNC_STAGES-1];

  // toggle every half period, so the monitor runs at dev_clk / 8
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      mon_cnt      <= '0;
      core_clk_mon <= 1'b0;
    end else if (mon_cnt == MON_LAST) begin
      mon_cnt      <= '0;
      core_clk_mon <= ~core_clk_mon;
    end else begin
      mon_cnt <= mon_cnt + 2'd1;
    end
  end

endmodule

`default_nettype wire

//--- src/console_port.sv
// console sink on apb, a written byte leaves as a one-cycle strobe and reads give a signature
`default_nettype none

`include "soc_periph_consts.svh"

module console_port (
  input  logic                      dev_clk,
  input  logic                      rst_n,
  input  logic                      sel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  soc_periph_pkg::reg_idx_t  reg_idx,
  input  soc_periph_pkg::apb_data_t pwdata,
  output soc_periph_pkg::apb_data_t rdata,
  output logic [7:0]                console_byte,
  output logic                      console_valid
);

  import soc_periph_pkg::*;

  localparam pll_cfg_t SIG = `CONSOLE_SIG;

  logic wr_en;

  // any index takes the byte
  assign wr_en = sel && penable && pwrite;

  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      console_valid <= 1'b0;
    end else begin
      console_valid <= wr_en;
    end
  end

  // byte held until the next write
  always_ff @(posedge dev_clk) begin
    if (wr_en) begin
      console_byte <= pwdata[7:0];
    end
  end

  // odd word is the upper half of the signature
  assign rdata = reg_idx[0] ? SIG[63:32] : SIG[31:0];

endmodule

`default_nettype wire

//--- src/pll_cfg_regs.sv
// pll soft configuration registers, two 64-bit settings written as word pairs over apb
`default_nettype none

module pll_cfg_regs (
  input  logic                      dev_clk,
  input  logic                      rst_n,
  input  logic                      sel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  soc_periph_pkg::reg_idx_t  reg_idx,
  input  soc_periph_pkg::apb_data_t pwdata,
  output soc_periph_pkg::apb_data_t rdata,
  output soc_periph_pkg::pll_cfg_t  pll_cfg_1,
  output soc_periph_pkg::pll_cfg_t  pll_cfg_2,
  output logic                      pll_cfg_ctr
);

  import soc_periph_pkg::*;

  apb_data_t staging;
  logic      wr_en;

  assign wr_en = sel && penable && pwrite;

  // low word lands in staging, the odd index commits the full setting
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      staging   <= '0;
      pll_cfg_1 <= '0;
      pll_cfg_2 <= '0;
    end else if (wr_en) begin
      case (reg_idx)
        2'd0: staging <= pwdata;
        2'd1: pll_cfg_1 <= {pwdata, staging};
        2'd2: staging <= pwdata;
        2'd3: pll_cfg_2 <= {pwdata, staging};
        default: staging <= staging;
      endcase
    end
  end

  // pll takes its setting once both are programmed
  always_ff @(posedge dev_clk or negedge rst_n) begin
    if (!rst_n) begin
      pll_cfg_ctr <= 1'b0;
    end else begin
      pll_cfg_ctr <= (pll_cfg_1 != '0) && (pll_cfg_2 != '0);
    end
  end

  always_comb begin
    case (reg_idx)
      2'd0:    rdata = pll_cfg_1[31:0];
      2'd1:    rdata = pll_cfg_1[63:32];
      2'd2:    rdata = pll_cfg_2[31:0];
      default: rdata = pll_cfg_2[63:32];
    endcase
  end

endmodule

`default_nettype wire

//--- src/soc_periph_consts.svh
// shared widths, address map and timing constants, included by the package and the RTL
`ifndef SOC_PERIPH_CONSTS_SVH
`define SOC_PERIPH_CONSTS_SVH

// apb bus widths
`define PADDR_W 32
`define PDATA_W 32

// one pll setting, written as two data words
`define PLL_CFG_W 64

// paddr bits that pick the slot
`define SLOT_FIELD_HI 13
`define SLOT_FIELD_LO 12

// slot field values, pll at 0x1000 and console at 0x2000
`define PLL_SLOT 2'd1
`define CONSOLE_SLOT 2'd2

// console read signature
`define CONSOLE_SIG 64'hdeadbeaf12345678

// core reset synchronizer depth
`define RST_SYNC_STAGES 3

// dev_clk cycles per half period of the monitor clock
`define MON_HALF_PERIOD 4

`endif

//--- src/soc_periph_pkg.sv
// bus, register and slot types shared by the peripheral subsystem, compiled before the RTL
`default_nettype none

`include "soc_periph_consts.svh"

package soc_periph_pkg;

  // apb address and data words
  typedef logic [`PADDR_W-1:0] apb_addr_t;
  typedef logic [`PDATA_W-1:0] apb_data_t;

  // one 64-bit pll setting
  typedef logic [`PLL_CFG_W-1:0] pll_cfg_t;

  // word index inside a slot, paddr[3:2]
  typedef logic [1:0] reg_idx_t;

  // decoded target of an access
  typedef enum logic [1:0] {
    SLOT_NONE    = 2'd0,
    SLOT_PLL     = 2'd1,
    SLOT_CONSOLE = 2'd2
  } slot_t;

endpackage

`default_nettype wire

//--- src/soc_periph_top.sv
// peripheral subsystem top, connects the apb decoder, its slots and the clock and reset block
`default_nettype none

module soc_periph_top (
  input  logic                      dev_clk,
  input  logic                      rst_n,
  input  soc_periph_pkg::apb_addr_t paddr,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  soc_periph_pkg::apb_data_t pwdata,
  output soc_periph_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  output soc_periph_pkg::pll_cfg_t  pll_cfg_1,
  output soc_periph_pkg::pll_cfg_t  pll_cfg_2,
  output logic                      pll_cfg_ctr,
  output logic [7:0]                console_byte,
  output logic                      console_valid,
  output logic                      core_rst_n,
  output logic                      core_clk_mon
);

  import soc_periph_pkg::*;

  logic      pll_sel;
  logic      console_sel;
  reg_idx_t  reg_idx;
  apb_data_t pll_rdata;
  apb_data_t console_rdata;

  apb_slot_decoder apb_slot_decoder_inst (
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pll_rdata     (pll_rdata),
    .console_rdata (console_rdata),
    .pll_sel       (pll_sel),
    .console_sel   (console_sel),
    .reg_idx       (reg_idx),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr)
  );

  pll_cfg_regs pll_cfg_regs_inst (
    .dev_clk     (dev_clk),
    .rst_n       (rst_n),
    .sel         (pll_sel),
    .penable     (penable),
    .pwrite      (pwrite),
    .reg_idx     (reg_idx),
    .pwdata      (pwdata),
    .rdata       (pll_rdata),
    .pll_cfg_1   (pll_cfg_1),
    .pll_cfg_2   (pll_cfg_2),
    .pll_cfg_ctr (pll_cfg_ctr)
  );

  console_port console_port_inst (
    .dev_clk       (dev_clk),
    .rst_n         (rst_n),
    .sel           (console_sel),
    .penable       (penable),
    .pwrite        (pwrite),
    .reg_idx       (reg_idx),
    .pwdata        (pwdata),
    .rdata         (console_rdata),
    .console_byte  (console_byte),
    .console_valid (console_valid)
  );

  clock_reset_gen clock_reset_gen_inst (
    .dev_clk      (dev_clk),
    .rst_n        (rst_n),
    .core_rst_n   (core_rst_n),
    .core_clk_mon (core_clk_mon)
  );

endmodule

`default_nettype wire

//--- verif/soc_periph_tb.sv
// directed testbench for the peripheral subsystem, run as the simulation top with the file list
`default_nettype none

`include "soc_periph_consts.svh"

module soc_periph_tb;

  import soc_periph_pkg::*;

  localparam int        CLK_PERIOD      = 100;
  localparam int        DRIVE_DELAY     = 10;
  localparam int        RESET_CYCLES    = 5;
  // tests take about 80 cycles, the rest is margin
  localparam int        WATCHDOG_CYCLES = 2000;
  localparam apb_addr_t PLL_BASE        = apb_addr_t'(`PLL_SLOT) << `SLOT_FIELD_LO;
  localparam apb_addr_t CONSOLE_BASE    = apb_addr_t'(`CONSOLE_SLOT) << `SLOT_FIELD_LO;
  localparam pll_cfg_t  CONSOLE_SIG     = `CONSOLE_SIG;

  logic        dev_clk;
  logic        rst_n;
  apb_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;
  pll_cfg_t    pll_cfg_1;
  pll_cfg_t    pll_cfg_2;
  logic        pll_cfg_ctr;
  logic [7:0]  console_byte;
  logic        console_valid;
  logic        core_rst_n;
  logic        core_clk_mon;

  integer      seed = 32'hab8b;
  // expected pll settings
  pll_cfg_t    exp_cfg1;
  pll_cfg_t    exp_cfg2;

  soc_periph_top soc_periph_top_inst (
    .dev_clk       (dev_clk),
    .rst_n         (rst_n),
    .paddr         (paddr),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .pll_cfg_1     (pll_cfg_1),
    .pll_cfg_2     (pll_cfg_2),
    .pll_cfg_ctr   (pll_cfg_ctr),
    .console_byte  (console_byte),
    .console_valid (console_valid),
    .core_rst_n    (core_rst_n),
    .core_clk_mon  (core_clk_mon)
  );

  initial begin
    dev_clk = 1'b0;
    forever #(CLK_PERIOD / 2) dev_clk = ~dev_clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge dev_clk);
    $display("timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_cfg(input string name, input pll_cfg_t exp, input pll_cfg_t act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "setting mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "flag mismatch");
    end
  endtask

  function automatic apb_addr_t word_addr(input apb_addr_t base, input int idx);
    return base + apb_addr_t'(idx * 4);
  endfunction

  // next drive point, a little after the rising edge
  task automatic next_cycle();
    @(posedge dev_clk);
    #(DRIVE_DELAY);
  endtask

  // returns just after the edge that commits the write
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    next_cycle();
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    #1;
    check_bit("pready", 1'b1, pready);
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    next_cycle();
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    next_cycle();
    penable = 1'b1;
    #1;
    check_bit("pready", 1'b1, pready);
    data = prdata;
    err  = pslverr;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic check_idle_outputs();
    check_cfg("pll_cfg_1", '0, pll_cfg_1);
    check_cfg("pll_cfg_2", '0, pll_cfg_2);
    check_bit("pll_cfg_ctr", 1'b0, pll_cfg_ctr);
    check_bit("console_valid", 1'b0, console_valid);
    check_bit("core_rst_n", 1'b0, core_rst_n);
    check_bit("core_clk_mon", 1'b0, core_clk_mon);
  endtask

  task automatic test_reset();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) next_cycle();
    check_idle_outputs();
    rst_n = 1'b1;
    #1;
    check_idle_outputs();
  endtask

  // starts right after reset release, edge k counted from there
  task automatic test_clock_reset();
    logic exp_mon;
    for (int k = 1; k <= 16; k++) begin
      next_cycle();
      exp_mon = ((k / 4) % 2) == 1;
      check_bit("core_rst_n", k >= 3, core_rst_n);
      check_bit("core_clk_mon", exp_mon, core_clk_mon);
    end
  endtask

  task automatic read_pll_word(input int idx, input apb_data_t exp);
    apb_data_t rd;
    logic      err;
    apb_read(word_addr(PLL_BASE, idx), rd, err);
    check_data("prdata", exp, rd);
    check_bit("pslverr", 1'b0, err);
  endtask

  task automatic test_pll_regs();
    apb_data_t w0;
    apb_data_t w1;
    apb_data_t w2;
    apb_data_t w3;
    w0 = $random(seed);
    w1 = $random(seed);
    w2 = $random(seed);
    w3 = $random(seed);
    // low word only stages, nothing commits yet
    apb_write(word_addr(PLL_BASE, 0), w0);
    check_cfg("pll_cfg_1", exp_cfg1, pll_cfg_1);
    apb_write(word_addr(PLL_BASE, 1), w1);
    exp_cfg1 = {w1, w0};
    check_cfg("pll_cfg_1", exp_cfg1, pll_cfg_1);
    read_pll_word(0, w0);
    read_pll_word(1, w1);
    check_bit("pll_cfg_ctr", 1'b0, pll_cfg_ctr);
    apb_write(word_addr(PLL_BASE, 2), w2);
    apb_write(word_addr(PLL_BASE, 3), w3);
    exp_cfg2 = {w3, w2};
    check_cfg("pll_cfg_2", exp_cfg2, pll_cfg_2);
    check_cfg("pll_cfg_1", exp_cfg1, pll_cfg_1);
    check_bit("pll_cfg_ctr", 1'b0, pll_cfg_ctr);
    next_cycle();
    check_bit("pll_cfg_ctr", 1'b1, pll_cfg_ctr);
    read_pll_word(0, exp_cfg1[31:0]);
    read_pll_word(1, exp_cfg1[63:32]);
    read_pll_word(2, exp_cfg2[31:0]);
    read_pll_word(3, exp_cfg2[63:32]);
  endtask

  task automatic test_console();
    apb_data_t rnd;
    apb_data_t rd;
    logic      err;
    rnd = $random(seed);
    check_bit("console_valid", 1'b0, console_valid);
    apb_write(word_addr(CONSOLE_BASE, 0), rnd);
    check_bit("console_valid", 1'b1, console_valid);
    check_data("console_byte", {24'd0, rnd[7:0]}, {24'd0, console_byte});
    next_cycle();
    check_bit("console_valid", 1'b0, console_valid);
    apb_read(word_addr(CONSOLE_BASE, 0), rd, err);
    check_data("prdata", CONSOLE_SIG[31:0], rd);
    check_bit("pslverr", 1'b0, err);
    apb_read(word_addr(CONSOLE_BASE, 1), rd, err);
    check_data("prdata", CONSOLE_SIG[63:32], rd);
    check_bit("pslverr", 1'b0, err);
  endtask

  task automatic test_unmapped();
    apb_data_t rd;
    logic      err;
    apb_read(32'h0000_0008, rd, err);
    check_bit("pslverr", 1'b1, err);
    check_data("prdata", '0, rd);
    apb_read(32'h0000_3004, rd, err);
    check_bit("pslverr", 1'b1, err);
    check_data("prdata", '0, rd);
    // odd indexes would commit a pll setting if decoded as the pll slot
    apb_write(32'h0000_0004, $random(seed));
    check_bit("console_valid", 1'b0, console_valid);
    apb_write(32'h0000_300c, $random(seed));
    check_bit("console_valid", 1'b0, console_valid);
    check_cfg("pll_cfg_1", exp_cfg1, pll_cfg_1);
    check_cfg("pll_cfg_2", exp_cfg2, pll_cfg_2);
  endtask

  initial begin
    rst_n    = 1'b0;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    exp_cfg1 = '0;
    exp_cfg2 = '0;
    test_reset();
    test_clock_reset();
    test_pll_regs();
    test_console();
    test_unmapped();
    repeat (2) next_cycle();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/soc_periph_pkg.sv
src/apb_slot_decoder.sv
src/pll_cfg_regs.sv
src/console_port.sv
src/clock_reset_gen.sv
src/soc_periph_top.sv
verif/soc_periph_tb.sv
